/* src.f */
design/usb_txn_pkg.sv
design/usb_txn_if.sv
design/usb_rx_decoder.sv
design/usb_txn_ctrl.sv
design/usb_tx_sequencer.sv
design/usb_device_txn.sv
dv/tb_usb_device_txn.sv

/* Bender.yml */
package:
  name: usb_device_txn

sources:
  - design/usb_txn_pkg.sv
  - design/usb_txn_if.sv
  - design/usb_rx_decoder.sv
  - design/usb_txn_ctrl.sv
  - design/usb_tx_sequencer.sv
  - design/usb_device_txn.sv
  - target: test
    files:
      - dv/tb_usb_device_txn.sv

/* dv/tb_usb_device_txn.sv */
// directed testbench for the usb device transaction layer, ep0 control, bulk in/out and sof
`timescale 1ns/1ns

module tb_usb_device_txn;

    localparam int clk_period = 10;
    // per-test cycle budget: reset, setup, 4 ep0 reads, 3 bulk reads, bulk out, sof/others
    localparam int worst_cycles = 10 + 40 + 4 * 45 + 60 + 3 * 45 + 30 + 25;

    logic                   clk;
    logic                   rstn;
    usb_txn_pkg::pid_e      rp_pid;
    usb_txn_pkg::ep_num_t   rp_endp;
    logic                   rp_byte_en;
    usb_txn_pkg::byte_t     rp_byte;
    logic                   rp_fin;
    logic                   rp_okay;
    logic                   tp_sta;
    usb_txn_pkg::pid_e      tp_pid;
    logic                   tp_byte_req;
    usb_txn_pkg::byte_t     tp_byte;
    logic                   tp_fin_n;
    logic                   sot;
    logic                   sof;
    usb_txn_pkg::setup_t    ep00_setup_cmd;
    usb_txn_pkg::resp_idx_t ep00_resp_idx;
    usb_txn_pkg::byte_t     ep00_resp;
    usb_txn_pkg::byte_t     ep81_data;
    logic                   ep81_valid;
    logic                   ep81_ready;
    usb_txn_pkg::byte_t     ep01_data;
    logic                   ep01_valid;

    integer             seed;
    logic               refill;            // bulk source owes a new byte
    int                 ready_cnt;         // ep81_ready pulses seen
    int                 ep01_cnt;          // ep01_valid pulses seen
    usb_txn_pkg::byte_t exp81[$];          // bytes taken by the dut
    usb_txn_pkg::byte_t rx_bytes[$];       // bytes of the last IN packet
    usb_txn_pkg::byte_t data_q[$];         // payload for the next data packet

    usb_device_txn i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------------------------------------------------------
    // application models
    // --------------------------------------------------------------------
    assign ep00_resp = ep00_resp_idx[7:0] ^ 8'h5a;  // response byte from index

    always @(posedge clk) begin
        if (ep81_ready && ep81_valid) begin  // byte handed to the sequencer
            exp81.push_back(ep81_data);
            ready_cnt++;
            refill = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (refill) begin
            ep81_data = usb_txn_pkg::byte_t'($random(seed));
            refill    = 1'b0;
        end
        if (ep01_valid)
            ep01_cnt++;  // one count per strobe cycle
    end

    initial begin
        #(2 * worst_cycles * clk_period);
        $display("watchdog expired, tests did not finish after %0d ns", $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------------------------
    // packet level helpers
    // --------------------------------------------------------------------
    // one finished packet, then sot/sof one cycle later and tp_sta two cycles later
    task automatic send_packet(input usb_txn_pkg::pid_e pid, input usb_txn_pkg::ep_num_t endp,
                               input logic okay, input logic exp_sot, input logic exp_sof,
                               input logic exp_sta, input usb_txn_pkg::pid_e exp_pid);
        @(negedge clk);
        rp_pid  = pid;
        rp_endp = endp;
        rp_fin  = 1'b1;
        rp_okay = okay;
        @(negedge clk);
        check(sot == exp_sot,
              $sformatf("sot=%0b expected %0b after %s", sot, exp_sot, pid.name()));
        check(sof == exp_sof,
              $sformatf("sof=%0b expected %0b after %s", sof, exp_sof, pid.name()));
        check(!tp_sta, $sformatf("tp_sta one cycle early after %s", pid.name()));
        rp_fin  = 1'b0;
        rp_okay = 1'b0;
        @(negedge clk);
        check(tp_sta == exp_sta,
              $sformatf("tp_sta=%0b expected %0b after %s", tp_sta, exp_sta, pid.name()));
        if (exp_sta)
            check(tp_pid == exp_pid,
                  $sformatf("tp_pid %s expected %s", tp_pid.name(), exp_pid.name()));
        check(!sot && !sof, "sot or sof wider than one cycle");
    endtask

    // bytes of data_q back to back, then the finishing cycle and the ACK
    task automatic send_data(input usb_txn_pkg::pid_e pid, input logic is_bulk_out);
        @(negedge clk);
        rp_pid = pid;
        foreach (data_q[i]) begin
            rp_byte_en = 1'b1;
            rp_byte    = data_q[i];
            @(negedge clk);
            check(ep01_valid == is_bulk_out,
                  $sformatf("ep01_valid=%0b on byte %0d", ep01_valid, i));
            if (is_bulk_out)
                check(ep01_data == data_q[i],
                      $sformatf("ep01_data %h expected %h", ep01_data, data_q[i]));
        end
        rp_byte_en = 1'b0;
        send_packet(pid, 4'd0, 1'b1, 1'b0, 1'b0, 1'b1, usb_txn_pkg::PID_ACK);
    endtask

    // SETUP token plus 8 command bytes, command must read back first byte lowest
    task automatic setup_request();
        usb_txn_pkg::setup_t exp_cmd;
        int                  i;
        send_packet(usb_txn_pkg::PID_SETUP, 4'd0, 1'b1, 1'b1, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        send_data(usb_txn_pkg::PID_DATA0, 1'b0);
        for (i = 0; i < 8; i++)
            exp_cmd[8 * i +: 8] = data_q[i];
        check(ep00_setup_cmd == exp_cmd,
              $sformatf("setup cmd %h expected %h", ep00_setup_cmd, exp_cmd));
    endtask

    // IN token, then byte requests until tp_fin_n drops
    task automatic read_in(input usb_txn_pkg::ep_num_t endp, input usb_txn_pkg::pid_e exp_pid);
        send_packet(usb_txn_pkg::PID_IN, endp, 1'b1, endp != 4'd0, 1'b0, 1'b1, exp_pid);
        rx_bytes.delete();
        @(negedge clk);  // sequencer holds the new length now
        tp_byte_req = 1'b1;
        @(negedge clk);
        while (tp_fin_n) begin
            rx_bytes.push_back(tp_byte);
            @(negedge clk);
        end
        tp_byte_req = 1'b0;
    endtask

    task automatic check_ep0_bytes(input int n, input int first_idx);
        int i;
        check(rx_bytes.size() == n, $sformatf("ep0 IN gave %0d bytes, expected %0d",
                                              rx_bytes.size(), n));
        for (i = 0; i < n; i++)
            check(rx_bytes[i] == (usb_txn_pkg::byte_t'(first_idx + i) ^ 8'h5a),
                  $sformatf("ep0 byte %0d is %h", first_idx + i, rx_bytes[i]));
        // index moves on by one per byte sent
        check(ep00_resp_idx == usb_txn_pkg::resp_idx_t'(first_idx + n),
              $sformatf("ep00_resp_idx %0d expected %0d", ep00_resp_idx, first_idx + n));
    endtask

    task automatic check_ep81_bytes(input int n);
        usb_txn_pkg::byte_t e;
        int                 i;
        check(rx_bytes.size() == n, $sformatf("ep81 IN gave %0d bytes", rx_bytes.size()));
        check(ready_cnt == n, $sformatf("%0d ep81_ready pulses, expected %0d", ready_cnt, n));
        for (i = 0; i < n; i++) begin
            e = exp81.pop_front();
            check(rx_bytes[i] == e,
                  $sformatf("ep81 byte %0d is %h expected %h", i, rx_bytes[i], e));
        end
    endtask

    // --------------------------------------------------------------------
    // directed tests
    // --------------------------------------------------------------------
    task automatic setup_capture();
        data_q = '{8'h21, 8'h09, 8'h34, 8'h12, 8'h78, 8'h56, 8'h00, 8'h00};
        setup_request();
    endtask

    task automatic control_read_split();
        data_q = '{8'h80, 8'h06, 8'h00, 8'h02, 8'h00, 8'h00, 8'h28, 8'h00};  // wLength 40
        setup_request();
        read_in(4'd0, usb_txn_pkg::PID_DATA1);
        check_ep0_bytes(32, 0);
        send_packet(usb_txn_pkg::PID_ACK, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        read_in(4'd0, usb_txn_pkg::PID_DATA0);
        check_ep0_bytes(8, 32);
        send_packet(usb_txn_pkg::PID_ACK, 4'd0, 1'b1, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        read_in(4'd0, usb_txn_pkg::PID_DATA1);
        check_ep0_bytes(0, 40);
        data_q = '{8'h00, 8'h09, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};  // host to device
        setup_request();
        read_in(4'd0, usb_txn_pkg::PID_DATA1);
        check_ep0_bytes(0, 0);
    endtask

    task automatic bulk_in_ep81();
        read_in(4'd1, usb_txn_pkg::PID_NAK);  // source empty
        check(rx_bytes.size() == 0, "NAKed bulk IN sent bytes");
        @(negedge clk);
        ep81_valid = 1'b1;
        exp81.delete();
        ready_cnt = 0;
        read_in(4'd1, usb_txn_pkg::PID_DATA0);
        check_ep81_bytes(32);
        send_packet(usb_txn_pkg::PID_ACK, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        ready_cnt = 0;
        read_in(4'd1, usb_txn_pkg::PID_DATA1);
        check_ep81_bytes(32);
        ep81_valid = 1'b0;
    endtask

    task automatic bulk_out_ep01();
        int start_cnt;
        send_packet(usb_txn_pkg::PID_OUT, 4'd1, 1'b1, 1'b1, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        start_cnt = ep01_cnt;
        data_q = '{8'hc3, 8'h17, 8'h00, 8'hff, 8'h6e};
        send_data(usb_txn_pkg::PID_DATA0, 1'b1);
        check(ep01_cnt - start_cnt == 5,
              $sformatf("%0d ep01_valid pulses", ep01_cnt - start_cnt));
    endtask

    task automatic sof_and_other_endpoints();
        send_packet(usb_txn_pkg::PID_SOF, 4'd0, 1'b1, 1'b0, 1'b1, 1'b0, usb_txn_pkg::PID_NAK);
        read_in(4'd5, usb_txn_pkg::PID_NAK);
        check(rx_bytes.size() == 0, "IN on endpoint 5 sent bytes");
        // corrupted packets are dropped
        send_packet(usb_txn_pkg::PID_SETUP, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        send_packet(usb_txn_pkg::PID_IN, 4'd1, 1'b0, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
        send_packet(usb_txn_pkg::PID_SOF, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, usb_txn_pkg::PID_NAK);
    endtask

    initial begin
        seed        = 32'h2b72_a84e;
        rstn        = 1'b0;
        rp_pid      = usb_txn_pkg::PID_SOF;
        rp_endp     = 4'd0;
        rp_byte_en  = 1'b0;
        rp_byte     = 8'h00;
        rp_fin      = 1'b0;
        rp_okay     = 1'b0;
        tp_byte_req = 1'b0;
        ep81_valid  = 1'b0;
        refill      = 1'b0;
        ready_cnt   = 0;
        ep01_cnt    = 0;
        ep81_data   = usb_txn_pkg::byte_t'($random(seed));
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        setup_capture();
        control_read_split();
        bulk_in_ep81();
        bulk_out_ep01();
        sof_and_other_endpoints();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* design/usb_device_txn.sv */
// usb full-speed device transaction layer top, decoder, controller and tx sequencer
`timescale 1ns/1ns

module usb_device_txn #(
    parameter int unsigned ep0_max_pkt  = 32,  // ep0 max packet size
    parameter int unsigned ep81_max_pkt = 32   // bulk IN packet length
) (
    input  logic                   clk,
    input  logic                   rstn,
    // --------------------------------------------------------------------
    // packet receiver
    // --------------------------------------------------------------------
    input  usb_txn_pkg::pid_e      rp_pid,
    input  usb_txn_pkg::ep_num_t   rp_endp,
    input  logic                   rp_byte_en,
    input  usb_txn_pkg::byte_t     rp_byte,
    input  logic                   rp_fin,
    input  logic                   rp_okay,
    // --------------------------------------------------------------------
    // packet transmitter
    // --------------------------------------------------------------------
    output logic                   tp_sta,
    output usb_txn_pkg::pid_e      tp_pid,
    input  logic                   tp_byte_req,
    output usb_txn_pkg::byte_t     tp_byte,
    output logic                   tp_fin_n,
    // status and control endpoint
    output logic                   sot,
    output logic                   sof,
    output usb_txn_pkg::setup_t    ep00_setup_cmd,
    output usb_txn_pkg::resp_idx_t ep00_resp_idx,
    input  usb_txn_pkg::byte_t     ep00_resp,
    // bulk in 0x81
    input  usb_txn_pkg::byte_t     ep81_data,
    input  logic                   ep81_valid,
    output logic                   ep81_ready,
    // bulk out 0x01
    output usb_txn_pkg::byte_t     ep01_data,
    output logic                   ep01_valid
);

    rx_event_if evt_if ();
    tx_load_if  load_if ();

    usb_rx_decoder i_rx_decoder (
        .clk        (clk),
        .rstn       (rstn),
        .rp_pid     (rp_pid),
        .rp_endp    (rp_endp),
        .rp_byte_en (rp_byte_en),
        .rp_byte    (rp_byte),
        .rp_fin     (rp_fin),
        .rp_okay    (rp_okay),
        .sot        (sot),
        .sof        (sof),
        .ep01_data  (ep01_data),
        .ep01_valid (ep01_valid),
        .evt        (evt_if.decoder)
    );

    usb_txn_ctrl #(
        .ep0_max_pkt  (ep0_max_pkt),
        .ep81_max_pkt (ep81_max_pkt)
    ) i_txn_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .ep81_valid (ep81_valid),
        .tp_sta     (tp_sta),
        .tp_pid     (tp_pid),
        .evt        (evt_if.controller),
        .load       (load_if.controller)
    );

    usb_tx_sequencer i_tx_sequencer (
        .clk           (clk),
        .rstn          (rstn),
        .tp_byte_req   (tp_byte_req),
        .ep00_resp     (ep00_resp),
        .ep81_data     (ep81_data),
        .ep81_valid    (ep81_valid),
        .tp_byte       (tp_byte),
        .tp_fin_n      (tp_fin_n),
        .ep81_ready    (ep81_ready),
        .ep00_resp_idx (ep00_resp_idx),
        .load          (load_if.sequencer)
    );

    assign ep00_setup_cmd = evt_if.setup_cmd;  // captured command straight from decoder

endmodule

/* design/usb_tx_sequencer.sv */
// transmit byte sequencer, counts out IN bytes on request and selects their source
`timescale 1ns/1ns

module usb_tx_sequencer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tp_byte_req,
    input  usb_txn_pkg::byte_t     ep00_resp,
    input  usb_txn_pkg::byte_t     ep81_data,
    input  logic                   ep81_valid,
    output usb_txn_pkg::byte_t     tp_byte,
    output logic                   tp_fin_n,
    output logic                   ep81_ready,
    output usb_txn_pkg::resp_idx_t ep00_resp_idx,
    tx_load_if.sequencer           load
);

    usb_txn_pkg::pkt_len_t cnt;       // bytes left in current packet
    usb_txn_pkg::tx_src_e  src_q;
    logic                  has_data;
    logic                  take;      // a byte goes out on this request
    usb_txn_pkg::byte_t    src_byte;

    // --------------------------------------------------------------------
    // source mux
    // --------------------------------------------------------------------
    assign has_data = (src_q == usb_txn_pkg::SRC_EP0) || ep81_valid;  // ep0 never runs dry
    assign src_byte = (src_q == usb_txn_pkg::SRC_EP0) ? ep00_resp : ep81_data;
    assign take     = tp_byte_req && (cnt != '0) && has_data;

    // bulk source sees the request directly
    assign ep81_ready = tp_byte_req && (cnt != '0) && (src_q == usb_txn_pkg::SRC_EP81);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt           <= '0;
            src_q         <= usb_txn_pkg::SRC_EP0;
            tp_fin_n      <= 1'b0;
            ep00_resp_idx <= '0;
        end else begin
            if (tp_byte_req)
                tp_fin_n <= take;  // low ends the packet
            if (load.load) begin
                cnt   <= load.len;
                src_q <= load.src;
            end else if (take) begin
                cnt <= cnt - 10'd1;
            end
            // index runs across packets of one control read
            if (load.idx_clr)
                ep00_resp_idx <= '0;
            else if (take && src_q == usb_txn_pkg::SRC_EP0)
                ep00_resp_idx <= ep00_resp_idx + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            tp_byte <= src_byte;
    end

    // between loads the count only goes down, so it cannot wrap
    a_cnt_no_wrap : assert property (@(posedge clk) disable iff (!rstn)
        !load.load |=> cnt <= $past(cnt));

endmodule

/* design/usb_txn_ctrl.sv */
// transaction controller, data toggles, ep0 remaining total, handshake and IN packet choice
`timescale 1ns/1ns

module usb_txn_ctrl #(
    parameter int unsigned ep0_max_pkt  = 32,
    parameter int unsigned ep81_max_pkt = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              ep81_valid,
    output logic              tp_sta,
    output usb_txn_pkg::pid_e tp_pid,
    rx_event_if.controller    evt,
    tx_load_if.controller     load
);

    localparam logic [15:0] ep0_max_w = 16'(ep0_max_pkt);  // compared against wLength

    logic                  tog0;       // ep0 toggle, 1 = DATA1
    logic                  tog81;      // ep 0x81 toggle
    logic [15:0]           ep0_total;  // bytes left in control read
    logic [15:0]           ep0_chunk;  // size of next ep0 IN packet
    logic                  on_ctrl;
    logic                  on_bulk;
    logic                  respond;    // event needs a tx packet
    usb_txn_pkg::pid_e     pid_d;
    usb_txn_pkg::pkt_len_t len_d;
    usb_txn_pkg::tx_src_e  src_d;

    assign on_ctrl   = (evt.endp == usb_txn_pkg::EP_CTRL);
    assign on_bulk   = (evt.endp == usb_txn_pkg::EP_BULK);
    assign ep0_chunk = (ep0_total >= ep0_max_w) ? ep0_max_w : ep0_total;
    assign respond   = evt.evt_valid && (evt.evt_kind == usb_txn_pkg::EVT_DATA ||
                                         evt.evt_kind == usb_txn_pkg::EVT_IN);

    // --------------------------------------------------------------------
    // response selection
    // --------------------------------------------------------------------
    always_comb begin
        pid_d = usb_txn_pkg::PID_NAK;  // unknown endpoints and empty bulk
        len_d = '0;
        src_d = usb_txn_pkg::SRC_EP0;
        if (evt.evt_kind == usb_txn_pkg::EVT_DATA) begin
            pid_d = usb_txn_pkg::PID_ACK;  // every data packet is accepted
        end else if (on_ctrl) begin
            pid_d = tog0 ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
            len_d = usb_txn_pkg::pkt_len_t'(ep0_chunk);  // may be 0, status/zlp
        end else if (on_bulk && ep81_valid) begin
            pid_d = tog81 ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
            len_d = usb_txn_pkg::pkt_len_t'(ep81_max_pkt);
            src_d = usb_txn_pkg::SRC_EP81;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tp_sta       <= 1'b0;
            load.load    <= 1'b0;
            load.idx_clr <= 1'b0;
            tog0         <= 1'b0;
            tog81        <= 1'b0;
            ep0_total    <= '0;
        end else begin
            tp_sta       <= respond;
            load.load    <= 1'b0;
            load.idx_clr <= 1'b0;
            if (evt.evt_valid) begin
                case (evt.evt_kind)
                    usb_txn_pkg::EVT_SETUP: begin
                        if (on_ctrl)
                            tog0 <= 1'b1;  // data stage starts with DATA1
                    end
                    usb_txn_pkg::EVT_DATA: begin
                        if (on_ctrl) begin
                            // setup data with device-to-host arms the read total
                            ep0_total <= (evt.setup_phase && evt.setup_cmd.dir_in) ?
                                         evt.setup_cmd.w_length : 16'd0;
                            load.idx_clr <= evt.setup_phase;
                        end
                    end
                    usb_txn_pkg::EVT_IN: begin
                        load.load <= 1'b1;
                        if (on_ctrl)
                            ep0_total <= ep0_total - ep0_chunk;
                    end
                    usb_txn_pkg::EVT_ACK: begin
                        if (on_ctrl)
                            tog0 <= ~tog0;
                        else if (on_bulk)
                            tog81 <= ~tog81;
                    end
                    default: ;  // OUT only moves the endpoint in the decoder
                endcase
            end
        end
    end

    // pid and packet shape held until the next response
    always_ff @(posedge clk) begin
        if (respond) begin
            tp_pid   <= pid_d;
            load.len <= len_d;
            load.src <= src_d;
        end
    end

    // an IN load never starts without a packet start
    a_load_with_sta : assert property (@(posedge clk) disable iff (!rstn)
        load.load |-> tp_sta);

endmodule

/* design/usb_rx_decoder.sv */
// receive-side decoder, classifies finished packets, captures SETUP and routes OUT bytes
`timescale 1ns/1ns

module usb_rx_decoder (
    input  logic                 clk,
    input  logic                 rstn,
    input  usb_txn_pkg::pid_e    rp_pid,
    input  usb_txn_pkg::ep_num_t rp_endp,
    input  logic                 rp_byte_en,
    input  usb_txn_pkg::byte_t   rp_byte,
    input  logic                 rp_fin,
    input  logic                 rp_okay,
    output logic                 sot,
    output logic                 sof,
    output usb_txn_pkg::byte_t   ep01_data,
    output logic                 ep01_valid,
    rx_event_if.decoder          evt
);

    logic                    pkt_ok;    // good packet finishing this cycle
    logic                    is_token;
    logic                    kind_ok;   // pid produces an event
    usb_txn_pkg::usb_event_e kind_d;
    usb_txn_pkg::ep_num_t    endp_q;
    logic                    setup_q;
    usb_txn_pkg::setup_t     cmd_q;

    assign pkt_ok   = rp_fin & rp_okay;
    assign is_token = (rp_pid == usb_txn_pkg::PID_SETUP) ||
                      (rp_pid == usb_txn_pkg::PID_OUT)   ||
                      (rp_pid == usb_txn_pkg::PID_IN);

    // --------------------------------------------------------------------
    // event classification
    // --------------------------------------------------------------------
    always_comb begin
        kind_d  = usb_txn_pkg::EVT_DATA;
        kind_ok = 1'b1;
        case (rp_pid)
            usb_txn_pkg::PID_SETUP: kind_d = usb_txn_pkg::EVT_SETUP;
            usb_txn_pkg::PID_OUT:   kind_d = usb_txn_pkg::EVT_OUT;
            usb_txn_pkg::PID_IN:    kind_d = usb_txn_pkg::EVT_IN;
            usb_txn_pkg::PID_ACK:   kind_d = usb_txn_pkg::EVT_ACK;
            usb_txn_pkg::PID_DATA0,
            usb_txn_pkg::PID_DATA1: kind_d = usb_txn_pkg::EVT_DATA;
            default:                kind_ok = 1'b0;  // SOF, NAK, anything else
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            evt.evt_valid <= 1'b0;
            evt.evt_kind  <= usb_txn_pkg::EVT_DATA;
            endp_q        <= usb_txn_pkg::EP_CTRL;
            setup_q       <= 1'b0;
            sot           <= 1'b0;
            sof           <= 1'b0;
            ep01_valid    <= 1'b0;
        end else begin
            evt.evt_valid <= pkt_ok & kind_ok;
            if (pkt_ok)
                evt.evt_kind <= kind_d;
            // tokens set the endpoint for following data and handshakes
            if (pkt_ok && is_token) begin
                endp_q <= rp_endp;
                if (rp_endp == usb_txn_pkg::EP_CTRL)
                    setup_q <= (rp_pid == usb_txn_pkg::PID_SETUP);  // OUT/IN end the setup phase
            end
            // transfer start, SETUP on ep0 or IN/OUT elsewhere
            sot <= pkt_ok && ((rp_endp == usb_txn_pkg::EP_CTRL) ?
                              (rp_pid == usb_txn_pkg::PID_SETUP) :
                              (rp_pid == usb_txn_pkg::PID_IN || rp_pid == usb_txn_pkg::PID_OUT));
            sof <= pkt_ok && (rp_pid == usb_txn_pkg::PID_SOF);
            ep01_valid <= rp_byte_en && (endp_q == usb_txn_pkg::EP_BULK);  // bulk out strobe
        end
    end

    // --------------------------------------------------------------------
    // data bytes, setup shift register and bulk out
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rp_byte_en && endp_q == usb_txn_pkg::EP_CTRL && setup_q)
            cmd_q <= {rp_byte, cmd_q[63:8]};  // shift down, 8th byte ends on top
        if (rp_byte_en && endp_q == usb_txn_pkg::EP_BULK)
            ep01_data <= rp_byte;
    end

    assign evt.endp        = endp_q;
    assign evt.setup_phase = setup_q;
    assign evt.setup_cmd   = cmd_q;

    // receiver never finishes two packets back to back
    a_evt_single : assert property (@(posedge clk) disable iff (!rstn)
        evt.evt_valid |=> !evt.evt_valid);

endmodule

/* design/usb_txn_if.sv */
// internal event and IN-load interfaces between decoder, controller and sequencer
`timescale 1ns/1ns

// --------------------------------------------------------------------
// decoder to controller, one event per finished packet
// --------------------------------------------------------------------
interface rx_event_if;

    logic                    evt_valid;    // single-cycle pulse
    usb_txn_pkg::usb_event_e evt_kind;
    usb_txn_pkg::ep_num_t    endp;         // endpoint of latest token
    logic                    setup_phase;  // last ep0 token was SETUP
    usb_txn_pkg::setup_t     setup_cmd;

    // no back-pressure, the controller takes every event in its cycle
    modport decoder (
        output evt_valid, evt_kind, endp, setup_phase, setup_cmd
    );

    modport controller (
        input evt_valid, evt_kind, endp, setup_phase, setup_cmd
    );

endinterface

// --------------------------------------------------------------------
// controller to sequencer, starts an IN packet
// --------------------------------------------------------------------
interface tx_load_if;

    logic                  load;     // pulse with tp_sta on IN
    usb_txn_pkg::pkt_len_t len;      // bytes to send
    usb_txn_pkg::tx_src_e  src;      // where they come from
    logic                  idx_clr;  // restart ep0 response index

    modport controller (
        output load, len, src, idx_clr
    );

    // len and src only sampled on load
    modport sequencer (
        input load, len, src, idx_clr
    );

endinterface

/* design/usb_txn_pkg.sv */
// usb full-speed transaction layer shared types, pid codes and setup command layout
package usb_txn_pkg;

    // --------------------------------------------------------------------
    // packet identifiers
    // --------------------------------------------------------------------
    typedef enum logic [3:0] {
        PID_OUT   = 4'h1,  // token
        PID_IN    = 4'h9,  // token
        PID_SETUP = 4'hd,  // token
        PID_SOF   = 4'h5,  // frame marker, no endpoint meaning
        PID_DATA0 = 4'h3,
        PID_DATA1 = 4'hb,
        PID_ACK   = 4'h2,  // handshake
        PID_NAK   = 4'ha   // handshake
    } pid_e;

    // kinds of finished good packets passed to the controller
    typedef enum logic [2:0] {
        EVT_SETUP = 3'd0,
        EVT_OUT   = 3'd1,
        EVT_IN    = 3'd2,
        EVT_ACK   = 3'd3,
        EVT_DATA  = 3'd4   // DATA0 or DATA1
    } usb_event_e;

    // --------------------------------------------------------------------
    // scalar types
    // --------------------------------------------------------------------
    typedef logic [3:0] ep_num_t;    // endpoint number from a token
    typedef logic [7:0] byte_t;
    typedef logic [9:0] pkt_len_t;   // bytes in one IN packet, up to 1023
    typedef logic [8:0] resp_idx_t;  // ep0 response byte index

    // endpoints kept in this device
    localparam ep_num_t EP_CTRL = 4'd0;
    localparam ep_num_t EP_BULK = 4'd1;  // 0x81 in, 0x01 out

    // SETUP command as shifted in, first byte at [7:0]
    typedef struct packed {
        logic [15:0] w_length;   // [63:48]
        logic [15:0] w_index;    // [47:32]
        logic [15:0] w_value;    // [31:16]
        logic [7:0]  b_request;  // [15:8]
        logic        dir_in;     // bmRequestType[7], device to host
        logic [1:0]  req_type;   // standard / class / vendor
        logic [4:0]  recipient;  // [4:0]
    } setup_t;

    // byte source for the IN packet being sent
    typedef enum logic {
        SRC_EP0  = 1'b0,  // application response via index
        SRC_EP81 = 1'b1   // bulk valid/ready stream
    } tx_src_e;

endpackage
